// File: hw/board_cfg_pkg.sv
// Board configuration constants
// Widths, joystick and status bit positions, reset stretch and input polarity
package board_cfg_pkg;

    // Bus widths
    localparam int BOARD_JOY_W = 16;
    localparam int GAME_JOY_W  = 10;
    localparam int STATUS_W    = 32;
    localparam int GFX_LAYERS  = 4;

    // Board joystick word, button positions
    localparam int START1_BIT = 6;
    localparam int START2_BIT = 7;
    localparam int COIN_BIT   = 8;
    localparam int PAUSE_BIT  = 9;

    // OSD status word fields
    localparam int ST_ROT_BIT    = 2;
    localparam int ST_FLIP_BIT   = 3;
    localparam int ST_TEST_BIT   = 4;
    localparam int ST_PAUSE_BIT  = 5;
    localparam int ST_FX_LSB     = 6;   // Two-bit effects level
    localparam int ST_NO_FM_BIT  = 8;
    localparam int ST_NO_PSG_BIT = 9;

    // Core reset stretch, counter holds 0..RST_STRETCH_CYCLES
    localparam int RST_STRETCH_CYCLES = 16;
    localparam int RST_CNT_W          = $clog2(RST_STRETCH_CYCLES + 1);

    // Game side expects released inputs at 1
    localparam bit INPUTS_ACTIVE_LOW = 1'b1;

endpackage

// File: hw/board_io_pkg.sv
// Board I/O types
// Joystick, key, status and settings vectors and structs
package board_io_pkg;

    typedef logic [board_cfg_pkg::BOARD_JOY_W-1:0] board_joy_t;
    typedef logic [board_cfg_pkg::GAME_JOY_W-1:0]  game_joy_t;  // Bit 0..3 right, left, down, up
    typedef logic [board_cfg_pkg::GFX_LAYERS-1:0]  gfx_en_t;
    typedef logic [board_cfg_pkg::STATUS_W-1:0]    status_t;
    typedef logic [1:0]                            fxlevel_t;

    // Decoded keyboard, active high
    typedef struct packed {
        game_joy_t  joy1;
        game_joy_t  joy2;
        logic [1:0] start;
        logic [1:0] coin;
        logic       reset;
        logic       pause;
        logic       service;
        gfx_en_t    gfx;
    } key_bus_t;

    // Game inputs in game polarity
    typedef struct packed {
        game_joy_t  joy1;
        game_joy_t  joy2;
        logic [1:0] coin;
        logic [1:0] start;
        logic       service;
    } player_in_t;

    // DIP settings taken from the OSD
    typedef struct packed {
        logic     rot_control;
        logic     flip;         // Change forces a core reset
        logic     test;
        logic     pause_n;
        fxlevel_t fxlevel;
        logic     enable_fm;
        logic     enable_psg;
    } dip_set_t;

endpackage

// File: hw/board_reset_gen.sv
// Core reset generator
// Stretches any reset cause and releases a delayed active-low copy
`timescale 1ns/10ps

module board_reset_gen (
    input  logic clk_sys,
    input  logic game_rst,
    input  logic rst_req,
    input  logic downloading,
    input  logic flip_change,
    input  logic soft_rst,
    output logic core_rst,
    output logic core_rst_n
);
    import board_cfg_pkg::*;

    localparam logic [RST_CNT_W-1:0] CNT_LAST = RST_CNT_W'(RST_STRETCH_CYCLES);

    logic                 rst_cause;
    logic [RST_CNT_W-1:0] rst_cnt;
    logic                 pre_rst_n;

    // Power-on reset is one cause among the others
    assign rst_cause = game_rst | rst_req | downloading | flip_change | soft_rst;

    always_ff @(posedge clk_sys) begin
        if (rst_cause) begin
            rst_cnt  <= '0;     // Restart the stretch
            core_rst <= 1'b1;
        end else if (rst_cnt != CNT_LAST) begin
            rst_cnt  <= rst_cnt + 1'b1;
            core_rst <= 1'b1;
        end else begin
            core_rst <= 1'b0;
        end
    end

    // Falls together with core_rst rising, released two edges after it drops
    always_ff @(posedge clk_sys) begin
        if (rst_cause || core_rst) begin
            pre_rst_n  <= 1'b0;
            core_rst_n <= 1'b0;
        end else begin
            pre_rst_n  <= 1'b1;
            core_rst_n <= pre_rst_n;
        end
    end

endmodule

// File: hw/board_dip_decode.sv
// DIP settings decoder
// Registers OSD status fields and flags a change of the flip setting
`timescale 1ns/10ps

module board_dip_decode (
    input  logic                  clk_sys,
    input  logic                  game_rst,
    input  board_io_pkg::status_t status,
    input  logic                  game_pause,
    output board_io_pkg::dip_set_t settings,
    output logic                  flip_change
);
    import board_cfg_pkg::*;
    import board_io_pkg::*;

    logic last_flip;

    function automatic dip_set_t decode(input status_t st, input logic pause);
        dip_set_t d;
        d.rot_control = st[ST_ROT_BIT];
        d.flip        = st[ST_FLIP_BIT];
        d.test        = st[ST_TEST_BIT];
        d.pause_n     = ~(st[ST_PAUSE_BIT] | pause);  // OSD or key pause
        d.fxlevel     = st[ST_FX_LSB +: $bits(fxlevel_t)];
        d.enable_fm   = ~st[ST_NO_FM_BIT];
        d.enable_psg  = ~st[ST_NO_PSG_BIT];
        return d;
    endfunction

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            settings <= decode('0, 1'b0);   // Same as an all-zero status word
        end else begin
            settings <= decode(status, game_pause);
        end
    end

    // One-cycle pulse the cycle after settings.flip moves
    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            last_flip   <= 1'b0;
            flip_change <= 1'b0;
        end else begin
            last_flip   <= settings.flip;
            flip_change <= settings.flip ^ last_flip;
        end
    end

endmodule

// File: hw/board_joy_map.sv
// Player input mapper
// Joystick sync, key merge, rotation and polarity, coin and start gathering
`timescale 1ns/10ps

module board_joy_map (
    input  logic                     clk_sys,
    input  logic                     game_rst,
    input  logic                     core_rst,
    input  board_io_pkg::board_joy_t board_joystick1,
    input  board_io_pkg::board_joy_t board_joystick2,
    input  board_io_pkg::key_bus_t   keys,
    input  logic                     rot_control,
    output board_io_pkg::player_in_t players,
    output logic                     joy_pause
);
    import board_cfg_pkg::*;
    import board_io_pkg::*;

    board_joy_t joy1_sync;
    board_joy_t joy2_sync;
    key_bus_t   keys_sync;
    logic [1:0] coin_raw;
    logic [1:0] start_raw;

    // Vertical screens swap the direction pairs, then polarity is applied
    function automatic game_joy_t map_joy(input game_joy_t joy, input logic rot);
        game_joy_t mapped;
        mapped = joy;
        if (rot) begin
            mapped[0] = joy[1];
            mapped[1] = joy[0];
            mapped[2] = joy[3];
            mapped[3] = joy[2];
        end
        return mapped ^ {GAME_JOY_W{INPUTS_ACTIVE_LOW}};
    endfunction

    // Single sync stage for the board joysticks and the keys
    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            joy1_sync <= '0;
            joy2_sync <= '0;
            keys_sync <= '0;
        end else begin
            joy1_sync <= board_joystick1;
            joy2_sync <= board_joystick2;
            keys_sync <= keys;
        end
    end

    assign joy_pause = joy1_sync[PAUSE_BIT] | joy2_sync[PAUSE_BIT];

    // Per-player coin, starts shared by both joysticks
    assign coin_raw  = {joy2_sync[COIN_BIT], joy1_sync[COIN_BIT]} | keys_sync.coin;
    assign start_raw = {joy1_sync[START2_BIT], joy1_sync[START1_BIT]}
                     | {joy2_sync[START2_BIT], joy2_sync[START1_BIT]}
                     | keys_sync.start;

    always_ff @(posedge clk_sys) begin
        if (core_rst) begin
            players <= {$bits(player_in_t){INPUTS_ACTIVE_LOW}};   // All released
        end else begin
            players.joy1    <= map_joy(joy1_sync[GAME_JOY_W-1:0] | keys_sync.joy1, rot_control);
            players.joy2    <= map_joy(joy2_sync[GAME_JOY_W-1:0] | keys_sync.joy2, rot_control);
            players.coin    <= coin_raw ^ {2{INPUTS_ACTIVE_LOW}};
            players.start   <= start_raw ^ {2{INPUTS_ACTIVE_LOW}};
            players.service <= keys_sync.service ^ INPUTS_ACTIVE_LOW;
        end
    end

endmodule

// File: hw/board_ctrl_toggle.sv
// Control toggles
// Pause and graphics-layer toggles, soft reset pulse from the reset key
`timescale 1ns/10ps

module board_ctrl_toggle (
    input  logic                   clk_sys,
    input  logic                   core_rst,
    input  board_io_pkg::key_bus_t keys,
    input  logic                   joy_pause,
    output logic                   game_pause,
    output board_io_pkg::gfx_en_t  gfx_en,
    output logic                   soft_rst
);
    import board_cfg_pkg::*;
    import board_io_pkg::*;

    logic    last_pause;
    logic    last_joypause;
    logic    last_reset;
    gfx_en_t last_gfx;
    logic    pause_edge;

    assign pause_edge = (keys.pause && !last_pause) || (joy_pause && !last_joypause);

    // Previous values keep tracking through reset, so a held key is not an edge
    always_ff @(posedge clk_sys) begin
        last_pause    <= keys.pause;
        last_joypause <= joy_pause;
        last_reset    <= keys.reset;
        last_gfx      <= keys.gfx;
    end

    always_ff @(posedge clk_sys) begin
        if (core_rst) begin
            game_pause <= 1'b0;
            gfx_en     <= '1;   // Every layer shown
            soft_rst   <= 1'b0;
        end else begin
            if (pause_edge) begin
                game_pause <= ~game_pause;
            end
            for (int i = 0; i < GFX_LAYERS; i++) begin
                if (keys.gfx[i] && !last_gfx[i]) begin
                    gfx_en[i] <= ~gfx_en[i];
                end
            end
            soft_rst <= keys.reset && !last_reset;  // Single cycle
        end
    end

endmodule

// File: hw/board_top.sv
// Board glue top level
// Reset generator, DIP decoder, joystick mapper and control toggles
`timescale 1ns/10ps

module board_top (
    input  logic                     clk_sys,
    input  logic                     game_rst,
    input  logic                     rst_req,
    input  logic                     downloading,
    input  board_io_pkg::board_joy_t board_joystick1,
    input  board_io_pkg::board_joy_t board_joystick2,
    input  board_io_pkg::key_bus_t   keys,
    input  board_io_pkg::status_t    status,
    output logic                     core_rst,
    output logic                     core_rst_n,
    output board_io_pkg::player_in_t players,
    output board_io_pkg::dip_set_t   settings,
    output logic                     game_pause,
    output board_io_pkg::gfx_en_t    gfx_en
);

    logic flip_change;  // From the DIP decoder
    logic joy_pause;    // Either joystick pause button
    logic soft_rst;     // Reset key edge

    board_reset_gen u_reset (
        .clk_sys     ( clk_sys     ),
        .game_rst    ( game_rst    ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .flip_change ( flip_change ),
        .soft_rst    ( soft_rst    ),
        .core_rst    ( core_rst    ),
        .core_rst_n  ( core_rst_n  )
    );

    board_dip_decode u_dip (
        .clk_sys     ( clk_sys     ),
        .game_rst    ( game_rst    ),
        .status      ( status      ),
        .game_pause  ( game_pause  ),
        .settings    ( settings    ),
        .flip_change ( flip_change )
    );

    board_joy_map u_joy (
        .clk_sys         ( clk_sys              ),
        .game_rst        ( game_rst             ),
        .core_rst        ( core_rst             ),
        .board_joystick1 ( board_joystick1      ),
        .board_joystick2 ( board_joystick2      ),
        .keys            ( keys                 ),
        .rot_control     ( settings.rot_control ),
        .players         ( players              ),
        .joy_pause       ( joy_pause            )
    );

    board_ctrl_toggle u_ctrl (
        .clk_sys    ( clk_sys    ),
        .core_rst   ( core_rst   ),
        .keys       ( keys       ),
        .joy_pause  ( joy_pause  ),
        .game_pause ( game_pause ),
        .gfx_en     ( gfx_en     ),
        .soft_rst   ( soft_rst   )
    );

endmodule

// File: tests/board_props.sv
// Bound assertions on the reset generator and the control toggles
// Soft reset pulse width, reset pair ordering, layer enables after reset
`timescale 1ns/10ps

module board_props #(
    parameter bit CHECK_GFX = 1'b0  // Toggle block side, else reset generator side
) (
    input logic                  clk_sys,
    input logic                  core_rst,
    input logic                  core_rst_n,
    input logic                  soft_rst,
    input board_io_pkg::gfx_en_t gfx_en
);

    soft_rst_one_cycle: assert property (@(posedge clk_sys) soft_rst |=> !soft_rst)
        else $error("soft_rst stayed high for more than one cycle");

    if (CHECK_GFX) begin : g_gfx
        gfx_all_on: assert property (@(posedge clk_sys) core_rst |=> gfx_en == '1)
            else $error("gfx_en not all ones after core_rst");
    end else begin : g_rst_n
        // Active-low copy never released ahead of core_rst
        rst_n_follows: assert property (@(posedge clk_sys) core_rst |-> !core_rst_n)
            else $error("core_rst_n high while core_rst is high");
    end

endmodule

bind board_ctrl_toggle board_props #(.CHECK_GFX(1'b1)) ctrl_props (
    .clk_sys    ( clk_sys  ),
    .core_rst   ( core_rst ),
    .core_rst_n ( 1'b0     ),
    .soft_rst   ( soft_rst ),
    .gfx_en     ( gfx_en   )
);

bind board_reset_gen board_props #(.CHECK_GFX(1'b0)) rst_props (
    .clk_sys    ( clk_sys    ),
    .core_rst   ( core_rst   ),
    .core_rst_n ( core_rst_n ),
    .soft_rst   ( soft_rst   ),
    .gfx_en     ( '1         )
);

// File: tests/board_tb.sv
// Directed testbench for the board glue top level
// Clock, reset, test tasks, compare tasks, run limit and summary
`timescale 1ns/10ps

module board_tb;
    import board_cfg_pkg::*;
    import board_io_pkg::*;

    localparam int CYCLE_LIMIT = 2000;
    localparam int STRETCH_HI  = RST_STRETCH_CYCLES + 1;   // Edges with core_rst high

    logic       clk_sys;
    logic       game_rst;
    logic       rst_req;
    logic       downloading;
    board_joy_t board_joystick1;
    board_joy_t board_joystick2;
    key_bus_t   keys;
    status_t    status;
    logic       core_rst;
    logic       core_rst_n;
    player_in_t players;
    dip_set_t   settings;
    logic       game_pause;
    gfx_en_t    gfx_en;

    int      seed = 32'h5e62_6008;
    int      errors = 0;
    int      checks = 0;
    int      tests = 0;
    int      mark = 0;              // Errors before the current test
    string   test_name = "power_on";
    logic    exp_pause = 1'b0;      // Model of the pause toggle
    gfx_en_t exp_gfx = '1;

    board_top board_top_i (.*);

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    initial begin : run_limit
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk_sys);
            cycles++;
        end
        $display("Timeout: no result after %0d cycles", cycles);
        $display("Test failed");
        $finish;
    end

    task automatic note_check(logic ok, string what, string exp_s, string act_s);
        checks++;
        if (!ok) begin
            errors++;
            $display("[FAIL] %s: %s expected %s actual %s", test_name, what, exp_s, act_s);
        end
    endtask

    task automatic check_joy(string what, game_joy_t exp, game_joy_t act);
        note_check(act === exp, what, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_players(string what, player_in_t exp, player_in_t act);
        note_check(act === exp, what, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_dip(string what, dip_set_t exp, dip_set_t act);
        note_check(act === exp, what, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_gfx(string what, gfx_en_t exp, gfx_en_t act);
        note_check(act === exp, what, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        note_check(act === exp, what, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_count(string what, int exp, int act);
        note_check(act == exp, what, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    // Reference model of the player path
    function automatic game_joy_t exp_joy(game_joy_t raw, logic rot);
        game_joy_t j;
        j = raw;
        if (rot) begin
            j[1:0] = {raw[0], raw[1]};  // Right and left trade places
            j[3:2] = {raw[2], raw[3]};
        end
        return j ^ {GAME_JOY_W{INPUTS_ACTIVE_LOW}};
    endfunction

    function automatic player_in_t exp_players(board_joy_t j1, board_joy_t j2,
                                               key_bus_t k, logic rot);
        player_in_t p;
        logic [1:0] coin;
        logic [1:0] start;
        coin      = {j2[COIN_BIT], j1[COIN_BIT]} | k.coin;
        start     = {j1[START2_BIT] | j2[START2_BIT], j1[START1_BIT] | j2[START1_BIT]} | k.start;
        p.joy1    = exp_joy(j1[GAME_JOY_W-1:0] | k.joy1, rot);
        p.joy2    = exp_joy(j2[GAME_JOY_W-1:0] | k.joy2, rot);
        p.coin    = coin ^ {2{INPUTS_ACTIVE_LOW}};
        p.start   = start ^ {2{INPUTS_ACTIVE_LOW}};
        p.service = k.service ^ INPUTS_ACTIVE_LOW;
        return p;
    endfunction

    function automatic dip_set_t exp_dip(status_t st, logic pause);
        dip_set_t d;
        d.rot_control = st[ST_ROT_BIT];
        d.flip        = st[ST_FLIP_BIT];
        d.test        = st[ST_TEST_BIT];
        d.pause_n     = !(st[ST_PAUSE_BIT] || pause);
        d.fxlevel     = {st[ST_FX_LSB + 1], st[ST_FX_LSB]};
        d.enable_fm   = !st[ST_NO_FM_BIT];
        d.enable_psg  = !st[ST_NO_PSG_BIT];
        return d;
    endfunction

    task automatic set_cause(int sel, logic v);
        case (sel)
            0: game_rst = v;
            1: rst_req = v;
            default: downloading = v;
        endcase
    endtask

    task automatic wait_rst_n(logic level, string what);
        int n;
        n = 0;
        while (core_rst_n !== level && n < 40) begin
            @(negedge clk_sys);
            n++;
        end
        if (core_rst_n !== level) begin
            errors++;
            $display("%s: core_rst_n stuck at %b waiting for %s", test_name, core_rst_n, what);
        end
    endtask

    // Starts on the first falling edge after the last cause edge
    task automatic measure_stretch(string what);
        int hi;
        int lo;
        hi = 0;
        lo = 0;
        while (core_rst === 1'b1 && hi < 64) begin
            hi++;
            @(negedge clk_sys);
        end
        while (core_rst_n !== 1'b1 && lo < 64) begin
            lo++;
            @(negedge clk_sys);
        end
        check_count({what, " core_rst length"}, STRETCH_HI, hi);
        check_count({what, " core_rst_n delay"}, 2, lo);
    endtask

    task automatic end_test();
        tests++;
        $display("%-14s finished, %0d mismatches", test_name, errors - mark);
        mark = errors;
    endtask

    task automatic test_reset_stretch();
        test_name = "reset_stretch";
        for (int sel = 0; sel < 3; sel++) begin
            wait_rst_n(1'b1, "idle");
            set_cause(sel, 1'b1);
            repeat (sel + 1) @(negedge clk_sys);    // Causes of different length
            set_cause(sel, 1'b0);
            measure_stretch($sformatf("cause %0d", sel));
        end
        end_test();
    endtask

    task automatic test_joy_map(input logic rot, input int rounds);
        logic [31:0] r;
        player_in_t  exp;
        player_in_t  held;
        for (int i = 0; i < rounds; i++) begin
            held = exp_players(board_joystick1, board_joystick2, keys, rot);
            r = $random(seed);
            board_joystick1 = r[15:0];
            board_joystick2 = r[31:16];
            board_joystick1[PAUSE_BIT] = 1'b0;      // Pause has its own test
            board_joystick2[PAUSE_BIT] = 1'b0;
            r = $random(seed);
            keys.joy1    = r[9:0];
            keys.joy2    = r[19:10];
            keys.start   = r[21:20];
            keys.coin    = r[23:22];
            keys.service = r[24];
            @(negedge clk_sys);
            check_players("players after one cycle", held, players);   // Still in the sync stage
            @(negedge clk_sys);
            exp = exp_players(board_joystick1, board_joystick2, keys, rot);
            check_joy("joy1", exp.joy1, players.joy1);
            check_joy("joy2", exp.joy2, players.joy2);
            check_players("players", exp, players);
        end
        board_joystick1 = '0;
        board_joystick2 = '0;
        keys = '0;
    endtask

    task automatic test_rot_dip();
        logic [31:0] r;
        test_name = "rot_dip";
        for (int i = 0; i < 6; i++) begin
            r = $random(seed);
            status = r;
            status[ST_FLIP_BIT] = 1'b0;             // Flip restarts the core
            status[ST_ROT_BIT] = i[0];
            @(negedge clk_sys);
            check_dip("settings", exp_dip(status, exp_pause), settings);
            test_joy_map(status[ST_ROT_BIT], 1);
        end
        status = '0;
        @(negedge clk_sys);
        end_test();
    endtask

    task automatic test_pause();
        test_name = "pause";
        keys.pause = 1'b1;
        @(negedge clk_sys);
        exp_pause = !exp_pause;
        check_bit("key press", exp_pause, game_pause);
        repeat (3) @(negedge clk_sys);
        check_bit("key held", exp_pause, game_pause);
        check_dip("pause_n from key", exp_dip(status, exp_pause), settings);
        keys.pause = 1'b0;
        board_joystick2[PAUSE_BIT] = 1'b1;
        repeat (2) @(negedge clk_sys);              // Through the sync stage
        exp_pause = !exp_pause;
        check_bit("joystick press", exp_pause, game_pause);
        board_joystick2[PAUSE_BIT] = 1'b0;
        @(negedge clk_sys);
        check_dip("pause_n from joystick", exp_dip(status, exp_pause), settings);
        status[ST_PAUSE_BIT] = 1'b1;
        @(negedge clk_sys);
        check_dip("pause_n from status", exp_dip(status, exp_pause), settings);
        status[ST_PAUSE_BIT] = 1'b0;
        @(negedge clk_sys);
        end_test();
    endtask

    task automatic test_gfx();
        test_name = "gfx";
        for (int i = 0; i < GFX_LAYERS; i++) begin
            keys.gfx[i] = 1'b1;
            @(negedge clk_sys);
            keys.gfx[i] = 1'b0;
            exp_gfx[i] = !exp_gfx[i];
            check_gfx($sformatf("layer %0d", i), exp_gfx, gfx_en);
        end
        keys.pause = 1'b1;                          // Enter the reset paused
        @(negedge clk_sys);
        keys.pause = 1'b0;
        exp_pause = !exp_pause;
        check_bit("pause before reset", exp_pause, game_pause);
        rst_req = 1'b1;
        keys.joy1[0] = 1'b1;                        // Would show as a press outside reset
        repeat (2) @(negedge clk_sys);
        check_players("players in reset", '1, players);
        rst_req = 1'b0;
        keys.joy1[0] = 1'b0;
        wait_rst_n(1'b1, "release");
        exp_gfx = '1;
        exp_pause = 1'b0;
        check_gfx("after reset", exp_gfx, gfx_en);
        check_bit("pause after reset", exp_pause, game_pause);
        end_test();
    endtask

    task automatic test_soft_flip();
        test_name = "soft_flip";
        keys.reset = 1'b1;
        @(negedge clk_sys);
        keys.reset = 1'b0;
        wait_rst_n(1'b0, "reset key");
        measure_stretch("reset key");
        status[ST_FLIP_BIT] = 1'b1;
        @(negedge clk_sys);
        check_bit("flip setting", 1'b1, settings.flip);
        wait_rst_n(1'b0, "flip change");
        measure_stretch("flip change");
        end_test();
    endtask

    initial begin
        game_rst = 1'b1;
        rst_req = 1'b0;
        downloading = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        keys = '0;
        status = '0;
        repeat (2) @(negedge clk_sys);
        game_rst = 1'b0;
        wait_rst_n(1'b1, "power-on release");
        test_reset_stretch();
        test_name = "joy_map";
        test_joy_map(1'b0, 8);
        end_test();
        test_rot_dip();
        test_pause();
        test_gfx();
        test_soft_flip();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: src.f
hw/board_cfg_pkg.sv
hw/board_io_pkg.sv
hw/board_reset_gen.sv
hw/board_dip_decode.sv
hw/board_joy_map.sv
hw/board_ctrl_toggle.sv
hw/board_top.sv
tests/board_props.sv
tests/board_tb.sv

// File: run.sh
#!/bin/sh
# Compile the board glue testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module board_tb -f src.f

# The simulation result is read from its output
out=$(./obj_dir/Vboard_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
